// ==== common/core_types_pkg.sv ====
`include "req_macros.svh"

package core_types_pkg;

    typedef logic [`XLEN-1:0] instr_word_t;

    // Which instruction word goes on to decode
    typedef enum logic [1:0] {
        FETCH_HELD   = 2'd0, // Replay the latched word
        FETCH_BUBBLE = 2'd1, // Send a no-op
        FETCH_NEW    = 2'd2  // Pass the incoming word
    } fetch_sel_e;

endpackage

// ==== common/data_req_if.sv ====
`timescale 1ns/1ps

interface data_req_if;

    logic mem_read;
    logic mem_write;
    logic access_d1; // Read or write one cycle ago
    logic access_d2; // Read or write two cycles ago
    logic new_access;
    logic freeze;

    modport tracker (
        output mem_read, mem_write, access_d1, access_d2, new_access, freeze
    );

    modport user (
        input mem_read, mem_write, access_d1, access_d2, new_access, freeze
    );

endinterface

// ==== common/mem_req_pkg.sv ====
`include "req_macros.svh"

package mem_req_pkg;

    typedef logic [`XLEN-1:0] addr_word_t;

    typedef enum logic [1:0] {
        ADDR_BRANCH = 2'd0, // Branch target pc plus imm
        ADDR_DATA   = 2'd1,
        ADDR_PC     = 2'd2
    } addr_src_e;

endpackage

// ==== common/req_macros.svh ====
`ifndef REQ_MACROS_SVH
`define REQ_MACROS_SVH

// Width of every instruction, address and data word
`define XLEN 32

// Returned by instruction memory when no new instruction is ready
`define FETCH_MISS 32'hBAD1_BAD1

`define BUBBLE_WORD {`XLEN{1'b0}}

`endif

// ==== fetch/fetch_tracker.sv ====
`timescale 1ns/1ps
`include "req_macros.svh"

module fetch_tracker
    import core_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instr_word_t instruction_in,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic        mul_en,
    input  logic        ack_mul,
    input  logic        zero_multi,
    data_req_if.user    dreq,
    output fetch_sel_e  fetch_sel,
    output instr_word_t held_instr
);

    instr_word_t latched_instr;
    instr_word_t latched_next;
    logic        mul_en_d1;
    logic        zero_multi_d1;
    logic        ack_mul_d1;
    logic        ack_mul_d2;
    logic        access_now;
    logic        is_marker;
    logic        mul_stall;
    logic        same_word;
    logic        miss_after_word;
    logic        repeat_access;
    logic        first_mul_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latched_instr <= `BUBBLE_WORD;
            mul_en_d1     <= 1'b0;
            zero_multi_d1 <= 1'b0;
            ack_mul_d1    <= 1'b0;
            ack_mul_d2    <= 1'b0;
        end else begin
            latched_instr <= latched_next;
            mul_en_d1     <= mul_en;
            zero_multi_d1 <= zero_multi;
            ack_mul_d1    <= ack_mul;
            ack_mul_d2    <= ack_mul_d1;
        end
    end

    assign access_now = mem_read || mem_write;
    assign is_marker  = (instruction_in == `FETCH_MISS);

    // Multiply started last cycle and has not reported a zero operand
    assign mul_stall = mul_en_d1 && !zero_multi_d1;

    assign same_word       = (latched_instr == instruction_in) && !dreq.access_d1;
    assign miss_after_word = (latched_instr != `BUBBLE_WORD) && is_marker && !dreq.access_d1;

    // Same strobe still asserted from the previous cycle
    assign repeat_access = access_now && dreq.access_d1;

    // Only the first cycle after ack_mul rose counts here
    assign first_mul_ack = ack_mul_d1 && !ack_mul_d2 && (dreq.mem_read || dreq.mem_write);

    always_comb begin
        if (dreq.access_d1 || mul_stall) begin
            fetch_sel = FETCH_HELD;
        end else if (zero_multi_d1 || same_word || miss_after_word) begin
            fetch_sel = FETCH_BUBBLE;
        end else begin
            fetch_sel = FETCH_NEW;
        end
    end

    always_comb begin
        if (mul_en && !ack_mul && !ack_mul_d1) begin
            latched_next = latched_instr; // Multiply still running
        end else if (repeat_access) begin
            if (dreq.access_d2 && !dreq.freeze) begin
                latched_next = `BUBBLE_WORD; // Second stage done, access retires
            end else begin
                latched_next = latched_instr;
            end
        end else if (!is_marker) begin
            latched_next = instruction_in;
        end else if (first_mul_ack) begin
            latched_next = latched_instr;
        end else begin
            latched_next = `BUBBLE_WORD;
        end
    end

    assign held_instr = latched_instr;

endmodule

// ==== files.f ====
+incdir+common
common/core_types_pkg.sv
common/mem_req_pkg.sv
common/data_req_if.sv
logic/data_tracker.sv
fetch/fetch_tracker.sv
logic/req_combiner.sv
logic/mem_request_top.sv
test/tb_clock.sv
test/mem_request_props.sv
test/mem_request_tb.sv

// ==== logic/data_tracker.sv ====
`timescale 1ns/1ps

module data_tracker (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic        d_ack,
    data_req_if.tracker dreq
);

    logic read_d1;
    logic read_d2;
    logic write_d1;
    logic write_d2;
    logic access_now;

    // Two stages of strobe history
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_d1  <= 1'b0;
            read_d2  <= 1'b0;
            write_d1 <= 1'b0;
            write_d2 <= 1'b0;
        end else begin
            read_d1  <= mem_read;
            read_d2  <= read_d1;
            write_d1 <= mem_write;
            write_d2 <= write_d1;
        end
    end

    assign access_now = mem_read || mem_write;

    assign dreq.mem_read  = mem_read;
    assign dreq.mem_write = mem_write;
    assign dreq.access_d1 = read_d1 || write_d1;
    assign dreq.access_d2 = read_d2 || write_d2;

    // A strobe with no access two cycles back starts a fresh two-cycle access
    assign dreq.new_access = access_now && !dreq.access_d2;

    // Memory back-pressure freezes the core regardless of history
    assign dreq.freeze = !d_ack || dreq.new_access;

endmodule

// ==== logic/mem_request_top.sv ====
`timescale 1ns/1ps
`include "req_macros.svh"

module mem_request_top
    import core_types_pkg::*;
    import mem_req_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             i_ack, // Fetch validity comes from the miss marker
    input  logic             d_ack,
    input  addr_word_t       imm,
    input  logic             branch_taken,
    input  instr_word_t      instruction_in,
    input  addr_word_t       pc,
    input  addr_word_t       mem_address,
    input  logic [`XLEN-1:0] stored_data,
    input  logic             mem_read,
    input  logic             mem_write,
    input  logic             mul_en,
    input  logic             ack_mul,
    input  logic             zero_multi,
    output addr_word_t       final_address,
    output instr_word_t      instruction_out,
    output logic [`XLEN-1:0] mem_store,
    output logic             freeze,
    output logic             mem_read_request,
    output logic             mem_write_request
);

    fetch_sel_e  fetch_sel;
    instr_word_t held_instr;

    data_req_if dreq_if ();

    data_tracker data_tracker_i (
        .clk       (clk),
        .rst       (rst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .d_ack     (d_ack),
        .dreq      (dreq_if.tracker)
    );

    fetch_tracker fetch_tracker_i (
        .clk            (clk),
        .rst            (rst),
        .instruction_in (instruction_in),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mul_en         (mul_en),
        .ack_mul        (ack_mul),
        .zero_multi     (zero_multi),
        .dreq           (dreq_if.user),
        .fetch_sel      (fetch_sel),
        .held_instr     (held_instr)
    );

    req_combiner req_combiner_i (
        .rst               (rst),
        .pc                (pc),
        .imm               (imm),
        .mem_address       (mem_address),
        .stored_data       (stored_data),
        .branch_taken      (branch_taken),
        .instruction_in    (instruction_in),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .fetch_sel         (fetch_sel),
        .held_instr        (held_instr),
        .dreq              (dreq_if.user),
        .final_address     (final_address),
        .instruction_out   (instruction_out),
        .mem_store         (mem_store),
        .freeze            (freeze),
        .mem_read_request  (mem_read_request),
        .mem_write_request (mem_write_request)
    );

endmodule

// ==== logic/req_combiner.sv ====
`timescale 1ns/1ps
`include "req_macros.svh"

module req_combiner
    import core_types_pkg::*;
    import mem_req_pkg::*;
(
    input  logic        rst,
    input  addr_word_t  pc,
    input  addr_word_t  imm,
    input  addr_word_t  mem_address,
    input  logic [`XLEN-1:0] stored_data,
    input  logic        branch_taken,
    input  instr_word_t instruction_in,
    input  logic        mem_read,
    input  logic        mem_write,
    input  fetch_sel_e  fetch_sel,
    input  instr_word_t held_instr,
    data_req_if.user    dreq,
    output addr_word_t  final_address,
    output instr_word_t instruction_out,
    output logic [`XLEN-1:0] mem_store,
    output logic        freeze,
    output logic        mem_read_request,
    output logic        mem_write_request
);

    addr_word_t branch_target;
    addr_src_e  addr_src;

    assign branch_target = pc + imm;

    // Branch redirect wins over a data access
    always_comb begin
        if (branch_taken) begin
            addr_src = ADDR_BRANCH;
        end else if (dreq.new_access) begin
            addr_src = ADDR_DATA;
        end else begin
            addr_src = ADDR_PC;
        end
    end

    always_comb begin
        if (rst) begin
            final_address = pc;
        end else begin
            case (addr_src)
                ADDR_BRANCH: final_address = branch_target;
                ADDR_DATA:   final_address = mem_address;
                default:     final_address = pc;
            endcase
        end
    end

    always_comb begin
        case (fetch_sel)
            FETCH_HELD:   instruction_out = held_instr;
            FETCH_BUBBLE: instruction_out = `BUBBLE_WORD;
            default: begin
                // A miss falls back to the last good word
                if (instruction_in == `FETCH_MISS) begin
                    instruction_out = held_instr;
                end else begin
                    instruction_out = instruction_in;
                end
            end
        endcase
    end

    assign mem_store         = stored_data;
    assign freeze            = dreq.freeze;
    assign mem_read_request  = mem_read;
    assign mem_write_request = mem_write;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    -f files.f \
    --top-module mem_request_tb \
    -o mem_request_sim

./obj_dir/mem_request_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

// ==== test/mem_request_props.sv ====
`timescale 1ns/1ps
`include "req_macros.svh"

module mem_request_props (
    input logic             clk,
    input logic             rst,
    input logic             d_ack,
    input logic             freeze,
    input logic             mem_read,
    input logic             mem_write,
    input logic             mem_read_request,
    input logic             mem_write_request,
    input logic             branch_taken,
    input logic [`XLEN-1:0] pc,
    input logic [`XLEN-1:0] imm,
    input logic [`XLEN-1:0] final_address
);

    // Back-pressure always stalls the core
    freeze_on_stall: assert property (@(posedge clk) !d_ack |-> freeze)
        else $error("freeze is low while d_ack is low");

    strobes_pass: assert property (@(posedge clk)
        mem_read_request == mem_read && mem_write_request == mem_write)
        else $error("request strobes differ from mem_read or mem_write");

    branch_redirect: assert property (@(posedge clk) disable iff (rst)
        branch_taken |-> final_address == pc + imm)
        else $error("final_address is not the branch target");

endmodule

// ==== test/mem_request_tb.sv ====
`timescale 1ns/1ps
`include "req_macros.svh"

module mem_request_tb;

    localparam int TEST_CYCLES = 64; // Reset, six tests and the idle gaps between them
    localparam int MARGIN_NS   = 200;

    logic             clk;
    logic             rst;
    logic             i_ack, d_ack, branch_taken;
    logic             mem_read, mem_write, mul_en, ack_mul, zero_multi;
    logic [`XLEN-1:0] imm, pc, mem_address, stored_data, instruction_in;
    logic [`XLEN-1:0] final_address, instruction_out, mem_store;
    logic             freeze, mem_read_request, mem_write_request;
    logic [31:0]      lfsr = 32'h9715_db37;
    int               errors = 0;
    int               checks = 0;

    tb_clock tb_clock_i (.clk(clk), .rst(rst));

    mem_request_top mem_request_top_i (.*);

    bind mem_request_top mem_request_props mem_request_props_i (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // Taps 32, 22, 2, 1
        return {state[30:0], feedback};
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], rand_bit()};
        end
        return word;
    endfunction

    // Nonzero, not the miss marker and not the word before
    function automatic logic [31:0] fresh_word(input logic [31:0] prev);
        logic [31:0] word;
        do begin
            word = rand_word();
        end while (word == prev || word == `FETCH_MISS || word == `BUBBLE_WORD);
        return word;
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s = %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_controls();
        d_ack          = 1'b1;
        branch_taken   = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mul_en         = 1'b0;
        ack_mul        = 1'b0;
        zero_multi     = 1'b0;
        instruction_in = `BUBBLE_WORD;
    endtask

    // Enough quiet cycles to empty every history register
    task automatic idle(input int cycles);
        repeat (cycles) begin
            next_cycle();
            clear_controls();
        end
    endtask

    task automatic fetch_cycle(input logic [31:0] word, input logic mul, input logic zero,
                               input logic [31:0] expected);
        next_cycle();
        instruction_in = word;
        mul_en         = mul;
        zero_multi     = zero;
        @(negedge clk);
        check("instruction_out", instruction_out, expected);
    endtask

    task automatic reset_state_test();
        logic [31:0] word;
        logic [31:0] prev;
        prev = `BUBBLE_WORD;
        next_cycle();
        pc = rand_word();
        @(negedge clk);
        check("freeze", 32'(freeze), 32'd0);
        check("instruction_out", instruction_out, `BUBBLE_WORD);
        check("final_address", final_address, pc);
        repeat (8) begin
            word = fresh_word(prev);
            next_cycle();
            instruction_in = word;
            pc             = rand_word();
            @(negedge clk);
            check("instruction_out", instruction_out, word);
            check("final_address", final_address, pc);
            prev = word;
        end
    endtask

    task automatic branch_test();
        repeat (8) begin
            next_cycle();
            branch_taken = 1'b1;
            pc           = rand_word();
            imm          = rand_word();
            stored_data  = rand_word();
            mem_read     = rand_bit();
            mem_write    = rand_bit();
            @(negedge clk);
            check("final_address", final_address, pc + imm);
            check("mem_store", mem_store, stored_data);
            check("mem_read_request", 32'(mem_read_request), 32'(mem_read));
            check("mem_write_request", 32'(mem_write_request), 32'(mem_write));
        end
    endtask

    task automatic held_load_test();
        logic [31:0] word;
        logic [31:0] addr;
        word = fresh_word(`BUBBLE_WORD);
        addr = rand_word();
        for (int k = 1; k <= 4; k++) begin
            next_cycle();
            mem_read       = 1'b1;
            d_ack          = 1'b0;
            mem_address    = addr;
            instruction_in = word;
            pc             = rand_word();
            @(negedge clk);
            // The access counts as new until it shows two cycles back
            check("final_address", final_address, (k < 3) ? addr : pc);
            check("freeze", 32'(freeze), 32'd1);
            check("instruction_out", instruction_out, word);
        end
        next_cycle();
        mem_read = 1'b0;
        d_ack    = 1'b1;
        @(negedge clk);
        check("instruction_out", instruction_out, word); // Load still one cycle back
        check("freeze", 32'(freeze), 32'd0);
        check("final_address", final_address, pc);
    endtask

    task automatic backpressure_test();
        repeat (5) begin
            next_cycle();
            d_ack = 1'b0;
            pc    = rand_word();
            @(negedge clk);
            check("freeze", 32'(freeze), 32'd1);
        end
        repeat (2) begin
            next_cycle();
            d_ack = 1'b1;
            @(negedge clk);
            check("freeze", 32'(freeze), 32'd0);
            check("final_address", final_address, pc);
        end
    endtask

    task automatic fetch_miss_test();
        logic [31:0] word;
        word = fresh_word(`BUBBLE_WORD);
        fetch_cycle(word, 1'b0, 1'b0, word);
        fetch_cycle(`FETCH_MISS, 1'b0, 1'b0, `BUBBLE_WORD); // Marker after a real word
        word = fresh_word(`BUBBLE_WORD);
        fetch_cycle(word, 1'b0, 1'b0, word);
        fetch_cycle(word, 1'b0, 1'b0, `BUBBLE_WORD); // Same word twice
        fetch_cycle(`FETCH_MISS, 1'b0, 1'b0, `BUBBLE_WORD);
    endtask

    task automatic multiply_test();
        logic [31:0] word;
        logic [31:0] next_word;
        word = fresh_word(`BUBBLE_WORD);
        fetch_cycle(word, 1'b0, 1'b0, word);
        fetch_cycle(`FETCH_MISS, 1'b1, 1'b0, `BUBBLE_WORD);
        repeat (3) begin
            fetch_cycle(`FETCH_MISS, 1'b1, 1'b0, word); // Stall replays the held word
        end
        fetch_cycle(`FETCH_MISS, 1'b1, 1'b1, word);
        next_word = fresh_word(word);
        fetch_cycle(next_word, 1'b0, 1'b0, `BUBBLE_WORD); // Zero operand seen last cycle
        word = fresh_word(next_word);
        fetch_cycle(word, 1'b0, 1'b0, word);
    endtask

    initial begin
        i_ack       = 1'b1;
        imm         = '0;
        pc          = '0;
        mem_address = '0;
        stored_data = '0;
        clear_controls();
        wait (!rst);
        reset_state_test();
        branch_test();
        idle(3);
        held_load_test();
        idle(3);
        backpressure_test();
        idle(3);
        fetch_miss_test();
        idle(3);
        multiply_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 10 + MARGIN_NS);
        $display("Timeout: tests did not finish within %0d ns", TEST_CYCLES * 10 + MARGIN_NS);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0; // Released at the same point the stimulus is driven
    end

endmodule
